/* all.f */
hdl/hps_io_pkg.sv
hdl/uio_decoder.sv
hdl/user_inputs.sv
hdl/sd_block_port.sv
hdl/file_download.sv
hdl/hps_io.sv
verification/hps_io_checker.sv
verification/hps_io_tb.sv

/* hdl/file_download.sv */
////////////////////
// file transfer from the host into the core
// first word of an fp_enable frame is the command, the rest is payload
// data bytes come out on ioctl_dout with a write pulse and an address
////////////////////

`timescale 1ns/1ps

module file_download
	import hps_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  word_t       io_din,
	output logic        ioctl_download,
	output byte_t       ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output byte_t       ioctl_dout
);

	fio_state_t  state;
	word_t       cmd;
	ioctl_addr_t addr;
	logic        wr;

	////////////////////
	// frame FSM
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= FIO_WAIT_CMD;
		end else if (!fp_enable) begin
			state <= FIO_WAIT_CMD;
		end else if (io_strobe && state == FIO_WAIT_CMD) begin
			state <= FIO_PAYLOAD;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe && state == FIO_WAIT_CMD)
			cmd <= io_din;
	end

	////////////////////
	// payload handling
	////////////////////
	// ioctl_wr trails the data strobe by one extra cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			wr             <= 1'b0;
		end else begin
			ioctl_wr <= wr;
			wr       <= 1'b0;
			if (fp_enable && io_strobe && state == FIO_PAYLOAD) begin
				case (cmd)
					FIO_FILE_INDEX: ioctl_index <= io_din[7:0];
					FIO_FILE_TX: begin
						// nonzero starts a new file at 0, zero closes it
						if (io_din[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							ioctl_download <= 1'b0;
						end
					end
					FIO_FILE_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din[7:0];
							addr       <= addr + 1'b1;
							wr         <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/hps_io.sv */
////////////////////
// host-to-core command bridge, top level
// connects the user-channel decoder to the input, SD and download blocks
// NUM_JOY selects how many joysticks the core gets (1 to 6)
////////////////////

`timescale 1ns/1ps

module hps_io
	import hps_io_pkg::*;
#(
	parameter int NUM_JOY = 6
) (
	input  logic        clk_sys,
	input  logic        reset,

	// host word channel
	input  logic        io_enable,
	input  logic        io_strobe,
	input  logic        fp_enable,
	input  word_t       io_din,
	output word_t       io_dout,

	// config and inputs
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output joy_t        joystick_0,
	output joy_t        joystick_1,
	output joy_t        joystick_2,
	output joy_t        joystick_3,
	output joy_t        joystick_4,
	output joy_t        joystick_5,
	output status_t     status,
	input  logic        status_set,
	input  status_t     status_in,
	output ps2_key_t    ps2_key,

	// SD block access
	input  lba_t        sd_lba,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  word_t       sd_req_type,
	output logic        sd_ack,
	output buff_addr_t  sd_buff_addr,
	output byte_t       sd_buff_dout,
	input  byte_t       sd_buff_din,
	output logic        sd_buff_wr,

	// file download
	output logic        ioctl_download,
	output byte_t       ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output byte_t       ioctl_dout
);

	word_t      wr_data;
	logic       cfg_wr;
	logic       joy_wr;
	logic [2:0] joy_sel;
	logic       joy_hi;
	logic       status_wr;
	logic [1:0] status_idx;
	logic       kbd_byte_wr;
	logic       kbd_clear;
	logic       kbd_done;
	logic       sd_start;
	logic       sd_wr_word;
	logic       sd_rd_word;
	logic       sd_end;
	word_t      sd_status_word;
	status_t    status_req;
	logic [3:0] status_flag;

	uio_decoder #(
		.NUM_JOY(NUM_JOY)
	) u_uio_decoder (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din),
		.status_req(status_req), .status_flag(status_flag),
		.sd_status_word(sd_status_word), .sd_lba(sd_lba),
		.sd_req_type(sd_req_type), .sd_buff_din(sd_buff_din),
		.io_dout(io_dout), .wr_data(wr_data),
		.cfg_wr(cfg_wr), .joy_wr(joy_wr), .joy_sel(joy_sel), .joy_hi(joy_hi),
		.status_wr(status_wr), .status_idx(status_idx),
		.kbd_byte_wr(kbd_byte_wr), .kbd_clear(kbd_clear), .kbd_done(kbd_done),
		.sd_start(sd_start), .sd_wr_word(sd_wr_word),
		.sd_rd_word(sd_rd_word), .sd_end(sd_end)
	);

	user_inputs #(
		.NUM_JOY(NUM_JOY)
	) u_user_inputs (
		.clk_sys(clk_sys), .reset(reset), .wr_data(wr_data),
		.cfg_wr(cfg_wr), .joy_wr(joy_wr), .joy_sel(joy_sel), .joy_hi(joy_hi),
		.status_wr(status_wr), .status_idx(status_idx),
		.kbd_byte_wr(kbd_byte_wr), .kbd_clear(kbd_clear), .kbd_done(kbd_done),
		.status_set(status_set), .status_in(status_in),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .joystick_2(joystick_2),
		.joystick_3(joystick_3), .joystick_4(joystick_4), .joystick_5(joystick_5),
		.status(status), .status_req(status_req), .status_flag(status_flag),
		.ps2_key(ps2_key)
	);

	sd_block_port u_sd_block_port (
		.clk_sys(clk_sys), .reset(reset),
		.sd_start(sd_start), .sd_wr_word(sd_wr_word),
		.sd_rd_word(sd_rd_word), .sd_end(sd_end), .wr_data(wr_data),
		.sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr),
		.sd_status_word(sd_status_word)
	);

	file_download u_file_download (
		.clk_sys(clk_sys), .reset(reset),
		.fp_enable(fp_enable), .io_strobe(io_strobe), .io_din(io_din),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout)
	);

endmodule

/* hdl/hps_io_pkg.sv */
////////////////////
// shared widths, types and command codes of the host command bridge
// imported by every block and by the testbench
////////////////////

package hps_io_pkg;

	// host channel and data widths
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	// [10] toggles per event, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] ps2_key_t;

	typedef logic [31:0] lba_t;
	typedef logic [8:0]  buff_addr_t;
	typedef logic [8:0]  word_cnt_t;
	typedef logic [26:0] ioctl_addr_t;

	// file-transfer frame
	typedef enum logic {
		FIO_WAIT_CMD,
		FIO_PAYLOAD
	} fio_state_t;

	// user channel commands
	localparam word_t CMD_CFG        = 16'h0001;
	localparam word_t CMD_JOY0       = 16'h0002;
	localparam word_t CMD_JOY1       = 16'h0003;
	localparam word_t CMD_PS2_KBD    = 16'h0005;
	localparam word_t CMD_JOY2       = 16'h0010;
	localparam word_t CMD_JOY3       = 16'h0011;
	localparam word_t CMD_JOY4       = 16'h0012;
	localparam word_t CMD_JOY5       = 16'h0013;
	localparam word_t CMD_SD_STATUS  = 16'h0016;
	localparam word_t CMD_SD_WRITE   = 16'h0017;
	localparam word_t CMD_SD_READ    = 16'h0018;
	localparam word_t CMD_STATUS     = 16'h001e;
	localparam word_t CMD_STATUS_REQ = 16'h0029;

	// file channel commands
	localparam word_t FIO_FILE_TX     = 16'h0053;
	localparam word_t FIO_FILE_TX_DAT = 16'h0054;
	localparam word_t FIO_FILE_INDEX  = 16'h0055;

endpackage

/* hdl/sd_block_port.sv */
////////////////////
// SD block access for one virtual disk
// acknowledge, buffer address and the delayed buffer write
// also packs the status word the host polls
////////////////////

`timescale 1ns/1ps

module sd_block_port
	import hps_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       sd_start,
	input  logic       sd_wr_word,
	input  logic       sd_rd_word,
	input  logic       sd_end,
	input  word_t      wr_data,
	input  logic       sd_rd,
	input  logic       sd_wr,
	output logic       sd_ack,
	output buff_addr_t sd_buff_addr,
	output byte_t      sd_buff_dout,
	output logic       sd_buff_wr,
	output word_t      sd_status_word
);

	// write delay line: stage 0 fires the write, stage 2 moves the address
	logic [2:0] wr_dly;
	logic       addr_step;

	// bit 3 was the config request, unused with one disk
	assign sd_status_word = {8'h00, 4'h5, 1'b0, 1'b1, sd_wr, sd_rd};

	assign addr_step = wr_dly[2] | sd_rd_word;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_ack     <= 1'b0;
			wr_dly     <= '0;
			sd_buff_wr <= 1'b0;
		end else begin
			wr_dly     <= {wr_dly[1:0], sd_wr_word};
			sd_buff_wr <= wr_dly[0];
			if (sd_end)
				sd_ack <= 1'b0;
			else if (sd_start)
				sd_ack <= 1'b1;
		end
	end

	////////////////////
	// buffer address
	////////////////////
	// saturates at the last byte of the sector
	always_ff @(posedge clk_sys) begin
		if (reset)
			sd_buff_addr <= '0;
		else if (sd_start)
			sd_buff_addr <= '0;
		else if (addr_step && !(&sd_buff_addr))
			sd_buff_addr <= sd_buff_addr + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (sd_wr_word)
			sd_buff_dout <= wr_data[7:0];
	end

endmodule

/* hdl/uio_decoder.sv */
////////////////////
// user-channel transaction decoder
// word 0 of a frame is the command, later words are counted payload
// turns command and count into single write strobes for the receivers
// and registers the word the host reads back
////////////////////

`timescale 1ns/1ps

module uio_decoder
	import hps_io_pkg::*;
#(
	parameter int NUM_JOY = 6
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  word_t      io_din,
	input  status_t    status_req,
	input  logic [3:0] status_flag,
	input  word_t      sd_status_word,
	input  lba_t       sd_lba,
	input  word_t      sd_req_type,
	input  byte_t      sd_buff_din,
	output word_t      io_dout,
	output word_t      wr_data,
	output logic       cfg_wr,
	output logic       joy_wr,
	output logic [2:0] joy_sel,
	output logic       joy_hi,
	output logic       status_wr,
	output logic [1:0] status_idx,
	output logic       kbd_byte_wr,
	output logic       kbd_clear,
	output logic       kbd_done,
	output logic       sd_start,
	output logic       sd_wr_word,
	output logic       sd_rd_word,
	output logic       sd_end
);

	word_t      cmd;
	word_cnt_t  word_cnt;
	logic       io_enable_d;
	logic       kbd_skip;
	logic       cmd_stb;
	logic       payload_stb;
	logic       enable_fall;
	logic       joy_cmd;
	logic [2:0] joy_idx;
	word_t      rd_word;

	assign cmd_stb     = io_enable & io_strobe & (word_cnt == '0);
	assign payload_stb = io_enable & io_strobe & (word_cnt != '0);
	assign enable_fall = io_enable_d & ~io_enable;

	// joystick commands are not contiguous
	always_comb begin
		joy_cmd = 1'b1;
		joy_idx = 3'd0;
		case (cmd)
			CMD_JOY0: joy_idx = 3'd0;
			CMD_JOY1: joy_idx = 3'd1;
			CMD_JOY2: joy_idx = 3'd2;
			CMD_JOY3: joy_idx = 3'd3;
			CMD_JOY4: joy_idx = 3'd4;
			CMD_JOY5: joy_idx = 3'd5;
			default:  joy_cmd = 1'b0;
		endcase
	end

	////////////////////
	// write strobes
	////////////////////
	assign wr_data     = io_din;
	assign cfg_wr      = payload_stb & (cmd == CMD_CFG);
	assign joy_wr      = payload_stb & joy_cmd & (joy_idx < NUM_JOY);
	assign joy_sel     = joy_idx;
	// word 1 is the low half, anything after goes to the high half
	assign joy_hi      = (word_cnt != 9'd1);
	assign status_wr   = payload_stb & (cmd == CMD_STATUS) & (word_cnt < 9'd5);
	assign status_idx  = word_cnt[1:0] - 2'd1;
	assign kbd_clear   = cmd_stb & (io_din == CMD_PS2_KBD);
	assign kbd_byte_wr = payload_stb & (cmd == CMD_PS2_KBD) & ~(&io_din[15:8]) & ~kbd_skip;
	assign kbd_done    = enable_fall & (cmd == CMD_PS2_KBD) & ~kbd_skip;
	assign sd_start    = cmd_stb & ((io_din == CMD_SD_WRITE) | (io_din == CMD_SD_READ));
	assign sd_wr_word  = payload_stb & (cmd == CMD_SD_WRITE);
	assign sd_rd_word  = payload_stb & (cmd == CMD_SD_READ);
	assign sd_end      = enable_fall;

	////////////////////
	// read-back word
	////////////////////
	always_comb begin
		rd_word = '0;
		if (word_cnt == '0) begin
			if (io_din == CMD_STATUS_REQ)
				rd_word = {8'h00, 4'hA, status_flag};
		end else begin
			case (cmd)
				CMD_SD_STATUS: begin
					case (word_cnt)
						9'd1:    rd_word = sd_status_word;
						9'd2:    rd_word = sd_lba[15:0];
						9'd3:    rd_word = sd_lba[31:16];
						9'd4:    rd_word = sd_req_type;
						default: rd_word = '0;
					endcase
				end
				CMD_SD_READ: rd_word = {8'h00, sd_buff_din};
				CMD_STATUS_REQ: begin
					case (word_cnt)
						9'd1:    rd_word = status_req[15:0];
						9'd2:    rd_word = status_req[31:16];
						9'd3:    rd_word = status_req[47:32];
						9'd4:    rd_word = status_req[63:48];
						default: rd_word = '0;
					endcase
				end
				default: rd_word = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_enable_d <= 1'b0;
			cmd         <= '0;
			word_cnt    <= '0;
			kbd_skip    <= 1'b0;
			io_dout     <= '0;
		end else begin
			io_enable_d <= io_enable;
			if (!io_enable) begin
				cmd      <= '0;
				word_cnt <= '0;
				kbd_skip <= 1'b0;
				io_dout  <= '0;
			end else if (io_strobe) begin
				if (~&word_cnt)
					word_cnt <= word_cnt + 1'b1;
				if (word_cnt == '0)
					cmd <= io_din;
				// a 0xFF high byte drops the rest of the key sequence
				if (payload_stb && cmd == CMD_PS2_KBD && (&io_din[15:8]))
					kbd_skip <= 1'b1;
				io_dout <= rd_word;
			end
		end
	end

endmodule

/* hdl/user_inputs.sv */
////////////////////
// config, joystick and status registers plus keyboard event decode
// written through strobes from the user-channel decoder
// status_set rises are counted and the core's status is held for readback
////////////////////

`timescale 1ns/1ps

module user_inputs
	import hps_io_pkg::*;
#(
	parameter int NUM_JOY = 6
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  word_t      wr_data,
	input  logic       cfg_wr,
	input  logic       joy_wr,
	input  logic [2:0] joy_sel,
	input  logic       joy_hi,
	input  logic       status_wr,
	input  logic [1:0] status_idx,
	input  logic       kbd_byte_wr,
	input  logic       kbd_clear,
	input  logic       kbd_done,
	input  logic       status_set,
	input  status_t    status_in,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output logic       direct_video,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output joy_t       joystick_2,
	output joy_t       joystick_3,
	output joy_t       joystick_4,
	output joy_t       joystick_5,
	output status_t    status,
	output status_t    status_req,
	output logic [3:0] status_flag,
	output ps2_key_t   ps2_key
);

	word_t       cfg;
	joy_t        joy_reg [6];
	logic        status_set_d;
	logic [31:0] kbd_raw;
	logic        pressed;
	logic        extended;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg <= '0;
		end else if (cfg_wr) begin
			cfg <= wr_data;
		end
	end

	////////////////////
	// joysticks
	////////////////////
	// sticks above NUM_JOY stay at zero
	for (genvar i = 0; i < 6; i++) begin : g_joy
		if (i < NUM_JOY) begin : g_used
			always_ff @(posedge clk_sys) begin
				if (reset)
					joy_reg[i] <= '0;
				else if (joy_wr && joy_sel == i && joy_hi)
					joy_reg[i][31:16] <= wr_data;
				else if (joy_wr && joy_sel == i)
					joy_reg[i][15:0] <= wr_data;
			end
		end else begin : g_unused
			assign joy_reg[i] = '0;
		end
	end

	assign joystick_0 = joy_reg[0];
	assign joystick_1 = joy_reg[1];
	assign joystick_2 = joy_reg[2];
	assign joystick_3 = joy_reg[3];
	assign joystick_4 = joy_reg[4];
	assign joystick_5 = joy_reg[5];

	////////////////////
	// status
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status       <= '0;
			status_flag  <= '0;
			status_set_d <= 1'b0;
		end else begin
			status_set_d <= status_set;
			if (status_wr)
				status[status_idx*16 +: 16] <= wr_data;
			if (status_set && !status_set_d)
				status_flag <= status_flag + 4'd1;
		end
	end

	// core's requested status, read back by the host with the flag
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d)
			status_req <= status_in;
	end

	////////////////////
	// keyboard
	////////////////////
	// F0 before the code marks a release, E0 ahead of that marks extended
	assign pressed  = (kbd_raw[15:8] != 8'hF0);
	assign extended = pressed ? (kbd_raw[15:8] == 8'hE0) : (kbd_raw[23:16] == 8'hE0);

	always_ff @(posedge clk_sys) begin
		if (kbd_clear)
			kbd_raw <= '0;
		else if (kbd_byte_wr)
			kbd_raw <= {kbd_raw[23:0], wr_data[7:0]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			ps2_key <= '0;
		else if (kbd_done)
			ps2_key <= {~ps2_key[10], pressed, extended, kbd_raw[7:0]};
	end

endmodule

/* verification/hps_io_checker.sv */
////////////////////
// protocol assertions on the bridge's core-side ports
// bound into hps_io, failures are counted for the testbench
////////////////////

`timescale 1ns/1ps

module hps_io_checker
	import hps_io_pkg::*;
(
	input logic        clk_sys,
	input logic        reset,
	input logic        sd_ack,
	input logic        sd_buff_wr,
	input logic        ioctl_download,
	input logic        ioctl_wr,
	input ioctl_addr_t ioctl_addr
);

	int          fail_count = 0;
	ioctl_addr_t last_addr;
	logic        have_prev;

	// address of the previous write in the current file
	always_ff @(posedge clk_sys) begin
		if (reset || !ioctl_download) begin
			have_prev <= 1'b0;
		end else if (ioctl_wr) begin
			have_prev <= 1'b1;
			last_addr <= ioctl_addr;
		end
	end

	a_buff_wr_ack: assert property (@(posedge clk_sys) disable iff (reset)
		sd_buff_wr |-> sd_ack)
		else begin
			$error("sector buffer write outside of sd_ack");
			fail_count++;
		end

	a_ioctl_wr_dl: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
		else begin
			$error("ioctl write outside of a download");
			fail_count++;
		end

	a_ioctl_addr_step: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wr && have_prev) |-> (ioctl_addr == last_addr + 1'b1))
		else begin
			$error("ioctl address did not advance by one");
			fail_count++;
		end

endmodule

bind hps_io hps_io_checker u_checker (
	.clk_sys(clk_sys),
	.reset(reset),
	.sd_ack(sd_ack),
	.sd_buff_wr(sd_buff_wr),
	.ioctl_download(ioctl_download),
	.ioctl_wr(ioctl_wr),
	.ioctl_addr(ioctl_addr)
);

/* verification/hps_io_tb.sv */
////////////////////
// testbench for the host command bridge
// plays random host transactions on the user and file channels,
// models the expected core-side results and compares them
// a 512-byte buffer RAM stands in for the core's sector buffer
////////////////////

`timescale 1ns/1ps

module hps_io_tb
	import hps_io_pkg::*;
();

	localparam int NUM_JOY = 6;
	localparam int TIMEOUT = 200;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        io_enable;
	logic        io_strobe;
	logic        fp_enable;
	word_t       io_din;
	word_t       io_dout;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joy_t        joystick_0;
	joy_t        joystick_1;
	joy_t        joystick_2;
	joy_t        joystick_3;
	joy_t        joystick_4;
	joy_t        joystick_5;
	status_t     status;
	logic        status_set;
	status_t     status_in;
	ps2_key_t    ps2_key;
	lba_t        sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	word_t       sd_req_type;
	logic        sd_ack;
	buff_addr_t  sd_buff_addr;
	byte_t       sd_buff_dout;
	byte_t       sd_buff_din;
	logic        sd_buff_wr;
	logic        ioctl_download;
	byte_t       ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_dout;

	// host words to send and words read back, one per strobe
	word_t       tx_q [$];
	word_t       rx_q [$];
	// download writes seen on the ioctl side
	ioctl_addr_t got_addr_q [$];
	byte_t       got_data_q [$];

	// sector buffer and its model
	byte_t       ram [512];
	byte_t       exp_ram [512];
	joy_t        exp_joy [6];
	status_t     exp_status;
	ps2_key_t    exp_key;

	string       test_name;
	int          n_checks = 0;
	int          n_errs = 0;
	int          test_checks0;
	int          test_errs0;

	always #5 clk_sys = ~clk_sys;

	hps_io #(
		.NUM_JOY(NUM_JOY)
	) UUT (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .fp_enable(fp_enable),
		.io_din(io_din), .io_dout(io_dout),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .joystick_2(joystick_2),
		.joystick_3(joystick_3), .joystick_4(joystick_4), .joystick_5(joystick_5),
		.status(status), .status_set(status_set), .status_in(status_in),
		.ps2_key(ps2_key),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_req_type(sd_req_type),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_din(sd_buff_din), .sd_buff_wr(sd_buff_wr),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout)
	);

	////////////////////
	// core-side models
	////////////////////
	assign sd_buff_din = ram[sd_buff_addr];

	always @(negedge clk_sys) begin
		if (sd_buff_wr === 1'b1)
			ram[sd_buff_addr] <= sd_buff_dout;
	end

	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			got_addr_q.push_back(ioctl_addr);
			got_data_q.push_back(ioctl_dout);
		end
	end

	// every address bit shows up in the pattern
	function automatic byte_t fill_byte(input int a);
		return byte_t'((a * 37) ^ (a >> 3));
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_word(input string what, input word_t exp, input word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_joy(input string what, input joy_t exp, input joy_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_status(input string what, input status_t exp, input status_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_key(input string what, input ps2_key_t exp, input ps2_key_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_addr(input string what, input ioctl_addr_t exp,
			input ioctl_addr_t act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errs++;
			$display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		test_checks0 = n_checks;
		test_errs0   = n_errs;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", test_name,
			n_checks - test_checks0, n_errs - test_errs0);
	endtask

	////////////////////
	// host side
	////////////////////
	task automatic report_timeout(input string what);
		n_errs++;
		$display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
	endtask

	// one frame of tx_q words, strobes 6 cycles apart
	task automatic send_frame(input logic file_ch);
		rx_q.delete();
		@(negedge clk_sys);
		if (file_ch)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		repeat (2) @(negedge clk_sys);
		foreach (tx_q[i]) begin
			io_din    = tx_q[i];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			rx_q.push_back(io_dout);
			repeat (5) @(negedge clk_sys);
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (4) @(negedge clk_sys);
		tx_q.delete();
	endtask

	task automatic wait_key_event(input logic toggle);
		int n;
		n = 0;
		while (ps2_key[10] !== toggle && n < TIMEOUT) begin
			n++;
			@(negedge clk_sys);
		end
		if (ps2_key[10] !== toggle)
			report_timeout("ps2_key event");
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (got_addr_q.size() < count && n < TIMEOUT) begin
			n++;
			@(negedge clk_sys);
		end
		if (got_addr_q.size() < count)
			report_timeout("ioctl write");
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic check_all_joys();
		check_joy("joystick_0", exp_joy[0], joystick_0);
		check_joy("joystick_1", exp_joy[1], joystick_1);
		check_joy("joystick_2", exp_joy[2], joystick_2);
		check_joy("joystick_3", exp_joy[3], joystick_3);
		check_joy("joystick_4", exp_joy[4], joystick_4);
		check_joy("joystick_5", exp_joy[5], joystick_5);
	endtask

	task automatic run_config_joy();
		word_t w;
		word_t hi;
		word_t exp;
		int    k;
		logic  two;
		word_t joy_cmd [6];
		joy_cmd = '{CMD_JOY0, CMD_JOY1, CMD_JOY2, CMD_JOY3, CMD_JOY4, CMD_JOY5};
		start_test("config_joy");
		for (int i = 0; i < 8; i++) begin
			w = word_t'($urandom);
			tx_q.push_back(CMD_CFG);
			tx_q.push_back(w);
			send_frame(1'b0);
			// buttons in 1:0, scandoubler in 4, direct video in 10
			exp = '0;
			exp[1:0] = w[1:0];
			exp[2] = w[4];
			exp[3] = w[10];
			check_word("config", exp,
				{12'h000, direct_video, forced_scandoubler, buttons});
		end
		for (int i = 0; i < 16; i++) begin
			k   = $urandom_range(5, 0);
			w   = word_t'($urandom);
			hi  = word_t'($urandom);
			two = ($urandom_range(1, 0) == 1);
			tx_q.push_back(joy_cmd[k]);
			tx_q.push_back(w);
			if (two)
				tx_q.push_back(hi);
			send_frame(1'b0);
			exp_joy[k][15:0] = w;
			if (two)
				exp_joy[k][31:16] = hi;
			check_all_joys();
		end
		end_test();
	endtask

	task automatic run_status();
		int      n;
		int      set_count;
		word_t   w;
		status_t last_in;
		start_test("status");
		set_count = 0;
		last_in   = '0;
		for (int i = 0; i < 6; i++) begin
			n = $urandom_range(4, 1);
			tx_q.push_back(CMD_STATUS);
			for (int j = 0; j < n; j++) begin
				w = word_t'($urandom);
				tx_q.push_back(w);
				exp_status[j*16 +: 16] = w;
			end
			send_frame(1'b0);
			check_status("status", exp_status, status);
		end
		for (int r = 0; r < 3; r++) begin
			n = $urandom_range(5, 1);
			for (int j = 0; j < n; j++) begin
				status_in  = {$urandom, $urandom};
				last_in    = status_in;
				status_set = 1'b1;
				repeat (2) @(negedge clk_sys);
				status_set = 1'b0;
				repeat (2) @(negedge clk_sys);
			end
			set_count += n;
			tx_q.push_back(CMD_STATUS_REQ);
			repeat (4) tx_q.push_back(16'h0000);
			send_frame(1'b0);
			check_word("request flag", {8'h00, 4'hA, 4'(set_count)}, rx_q[0]);
			for (int j = 0; j < 4; j++)
				check_word("request status", last_in[j*16 +: 16], rx_q[j+1]);
			check_word("idle read-back", 16'h0000, io_dout);
		end
		end_test();
	endtask

	task automatic run_keyboard();
		byte_t seq [$];
		byte_t code;
		logic  ext;
		logic  rel;
		logic  bad;
		start_test("keyboard");
		for (int i = 0; i < 20; i++) begin
			code = byte_t'($urandom_range(8'h7F, 8'h01));
			ext  = ($urandom_range(1, 0) == 1);
			rel  = ($urandom_range(1, 0) == 1);
			bad  = ($urandom_range(3, 0) == 0);
			seq.delete();
			if (ext)
				seq.push_back(8'hE0);
			if (rel)
				seq.push_back(8'hF0);
			seq.push_back(code);
			tx_q.push_back(CMD_PS2_KBD);
			foreach (seq[j])
				tx_q.push_back({byte_t'($urandom_range(254, 0)), seq[j]});
			// an FF high byte anywhere in the payload cancels the event
			if (bad)
				tx_q.insert($urandom_range(tx_q.size(), 1), {8'hFF, code});
			send_frame(1'b0);
			if (!bad) begin
				// a release sends F0 right before the code
				exp_key = {~exp_key[10], ~rel, ext, code};
				wait_key_event(exp_key[10]);
			end
			check_key(bad ? "skipped event" : "key event", exp_key, ps2_key);
		end
		end_test();
	endtask

	task automatic run_sd_write();
		int    n;
		word_t w;
		word_t exp;
		start_test("sd_write");
		n           = $urandom_range(24, 8);
		sd_rd       = ($urandom_range(1, 0) == 1);
		sd_wr       = ($urandom_range(1, 0) == 1);
		sd_lba      = $urandom;
		sd_req_type = word_t'($urandom);
		tx_q.push_back(CMD_SD_WRITE);
		for (int j = 0; j < n; j++) begin
			w = word_t'($urandom);
			tx_q.push_back(w);
			exp_ram[j] = w[7:0];
		end
		send_frame(1'b0);
		check_bit("sd_ack after frame", 1'b0, sd_ack);
		for (int j = 0; j < 512; j++)
			check_byte($sformatf("buffer byte %0d", j), exp_ram[j], ram[j]);
		tx_q.push_back(CMD_SD_STATUS);
		repeat (4) tx_q.push_back(16'h0000);
		send_frame(1'b0);
		exp      = '0;
		exp[0]   = sd_rd;
		exp[1]   = sd_wr;
		exp[2]   = 1'b1;
		exp[7:4] = 4'h5;
		check_word("sd status", exp, rx_q[1]);
		check_word("lba low", sd_lba[15:0], rx_q[2]);
		check_word("lba high", sd_lba[31:16], rx_q[3]);
		check_word("request type", sd_req_type, rx_q[4]);
		end_test();
	endtask

	task automatic run_sd_read();
		int n;
		start_test("sd_read");
		n = $urandom_range(40, 24);
		tx_q.push_back(CMD_SD_READ);
		repeat (n) tx_q.push_back(16'h0000);
		send_frame(1'b0);
		for (int j = 0; j < n; j++)
			check_word($sformatf("sector byte %0d", j), {8'h00, exp_ram[j]}, rx_q[j+1]);
		check_bit("sd_ack after frame", 1'b0, sd_ack);
		end_test();
	endtask

	task automatic run_download();
		int    n;
		byte_t idx;
		word_t w;
		byte_t data_q [$];
		start_test("download");
		for (int f = 0; f < 2; f++) begin
			idx = byte_t'($urandom_range(255, 1));
			tx_q.push_back(FIO_FILE_INDEX);
			tx_q.push_back({8'h00, idx});
			send_frame(1'b1);
			check_byte("ioctl_index", idx, ioctl_index);
			tx_q.push_back(FIO_FILE_TX);
			tx_q.push_back({8'h00, byte_t'($urandom_range(255, 1))});
			send_frame(1'b1);
			check_bit("download start", 1'b1, ioctl_download);
			got_addr_q.delete();
			got_data_q.delete();
			data_q.delete();
			n = $urandom_range(40, 10);
			tx_q.push_back(FIO_FILE_TX_DAT);
			for (int j = 0; j < n; j++) begin
				w = word_t'($urandom);
				tx_q.push_back(w);
				data_q.push_back(w[7:0]);
			end
			send_frame(1'b1);
			wait_writes(n);
			check_word("write count", word_t'(n), word_t'(got_addr_q.size()));
			for (int j = 0; j < n; j++) begin
				check_addr("ioctl_addr", ioctl_addr_t'(j), got_addr_q[j]);
				check_byte("ioctl_dout", data_q[j], got_data_q[j]);
			end
			tx_q.push_back(FIO_FILE_TX);
			tx_q.push_back({byte_t'($urandom), 8'h00});
			send_frame(1'b1);
			check_bit("download end", 1'b0, ioctl_download);
		end
		end_test();
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		void'($urandom(43));
		reset       = 1'b1;
		io_enable   = 1'b0;
		io_strobe   = 1'b0;
		fp_enable   = 1'b0;
		io_din      = '0;
		status_set  = 1'b0;
		status_in   = '0;
		sd_lba      = '0;
		sd_rd       = 1'b0;
		sd_wr       = 1'b0;
		sd_req_type = '0;
		exp_status  = '0;
		exp_key     = '0;
		for (int i = 0; i < 6; i++)
			exp_joy[i] = '0;
		for (int i = 0; i < 512; i++) begin
			ram[i]     = fill_byte(i);
			exp_ram[i] = fill_byte(i);
		end
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		repeat (2) @(negedge clk_sys);

		run_config_joy();
		run_status();
		run_keyboard();
		run_sd_write();
		run_sd_read();
		run_download();

		$display("total: %0d checks, %0d errors, %0d assertion failures",
			n_checks, n_errs, UUT.u_checker.fail_count);
		if (n_errs == 0 && UUT.u_checker.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
